//--- include/fetch_consts.svh
/*
 * Instruction fetch constants
 * Sizes of the parcel queue and of the memory fetch word.
 */

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// queue capacity in 16-bit parcels, 8, 12 or 16
`define FQ_DEPTH 8

// width of the count of parcels held or free in the queue
`define FQ_CNT_W ($clog2(`FQ_DEPTH + 1))

// memory word width in bits and parcels per word
`define FETCH_W 64
`define FETCH_PARCELS (`FETCH_W / 16)

`endif

//--- verilog/fetch_pkg.sv
/*
 * Fetch package
 * Instruction record, memory response record, FSM states and
 * the major opcodes used by the fetch stage.
 */

`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  // one instruction as handed to decode
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        is_comp;
    logic        err;
    logic        illegal;
  } ir_reg_t;

  // accepted memory response
  typedef struct packed {
    logic                valid;
    logic [`FETCH_W-1:0] rdata;
    logic                err;
    logic [31:0]         word_pc;
    logic [1:0]          first;
  } fetch_rsp_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_REQ,
    FS_WAIT,
    FS_HALT_ERR
  } fetch_state_e;

  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } rv_opcode_e;

endpackage

`default_nettype wire

//--- verilog/fetch_ctrl.sv
/*
 * Fetch control
 * Owns the fetch PC and runs the req/gnt/rvalid memory port with one
 * request in flight. Stale responses after a redirect are dropped.
 */

`default_nettype none

`include "fetch_consts.svh"

module fetch_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    req_i,
  input  logic [31:0]             boot_addr_i,
  output logic                    instr_req_o,
  output logic [31:0]             instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`FETCH_W-1:0]     instr_rdata_i,
  input  logic                    instr_err_i,
  input  logic [`FQ_CNT_W-1:0]    free_parcels_i,
  input  logic                    redirect_i,
  input  logic [31:0]             redirect_pc_i,
  output fetch_pkg::fetch_rsp_t   rsp_o,
  output logic                    busy_o
);

  fetch_pkg::fetch_state_e state_q, state_d;

  logic [31:0] fetch_pc_q;
  logic [31:0] addr_q;
  logic [1:0]  first_q;
  logic        discard_q;
  logic        booted_q;
  logic [31:0] next_pc;
  logic        launch;

  // boot address until the first launch or redirect
  assign next_pc = redirect_i ? redirect_pc_i : (booted_q ? fetch_pc_q : boot_addr_i);

  // a redirect empties the queue, so room is guaranteed then
  assign launch = req_i && (redirect_i || free_parcels_i >= `FQ_CNT_W'(`FETCH_PARCELS)) &&
                  (state_q == fetch_pkg::FS_IDLE ||
                   (state_q == fetch_pkg::FS_HALT_ERR && redirect_i));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      fetch_pkg::FS_IDLE: begin
        if (launch) begin
          state_d = fetch_pkg::FS_REQ;
        end
      end
      fetch_pkg::FS_REQ: begin
        if (instr_gnt_i) begin
          state_d = fetch_pkg::FS_WAIT;
        end
      end
      fetch_pkg::FS_WAIT: begin
        if (instr_rvalid_i) begin
          if (instr_err_i && !discard_q && !redirect_i) begin
            state_d = fetch_pkg::FS_HALT_ERR;
          end else begin
            state_d = fetch_pkg::FS_IDLE;
          end
        end
      end
      fetch_pkg::FS_HALT_ERR: begin
        if (launch) begin
          state_d = fetch_pkg::FS_REQ;
        end else if (redirect_i) begin
          state_d = fetch_pkg::FS_IDLE;
        end
      end
      default: state_d = fetch_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= fetch_pkg::FS_IDLE;
      fetch_pc_q <= '0;
      addr_q     <= '0;
      first_q    <= '0;
      discard_q  <= 1'b0;
      booted_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (launch || redirect_i) begin
        booted_q <= 1'b1;
      end
      // address and first parcel are frozen until the next launch
      if (launch) begin
        addr_q  <= {next_pc[31:3], 3'b000};
        first_q <= next_pc[2:1];
      end
      if (redirect_i) begin
        fetch_pc_q <= redirect_pc_i;
      end else if (state_q == fetch_pkg::FS_REQ && instr_gnt_i && !discard_q) begin
        fetch_pc_q <= addr_q + 32'(`FETCH_W / 8);
      end
      // a request already on the bus must still complete
      if (redirect_i && (state_q == fetch_pkg::FS_REQ ||
                         (state_q == fetch_pkg::FS_WAIT && !instr_rvalid_i))) begin
        discard_q <= 1'b1;
      end else if (state_q == fetch_pkg::FS_WAIT && instr_rvalid_i) begin
        discard_q <= 1'b0;
      end
    end
  end

  assign instr_req_o  = state_q == fetch_pkg::FS_REQ;
  assign instr_addr_o = addr_q;
  assign busy_o       = state_q == fetch_pkg::FS_REQ || state_q == fetch_pkg::FS_WAIT;

  assign rsp_o.valid   = instr_rvalid_i && state_q == fetch_pkg::FS_WAIT && !discard_q;
  assign rsp_o.rdata   = instr_rdata_i;
  assign rsp_o.err     = instr_err_i;
  assign rsp_o.word_pc = addr_q;
  assign rsp_o.first   = first_q;

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // memory must answer only a granted request
  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> state_q == fetch_pkg::FS_WAIT);

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
/*
 * Fetch queue
 * Circular buffer of 16-bit parcels with pc and error tags. Aligns up to
 * two 16/32-bit instructions at its head.
 */

`default_nettype none

`include "fetch_consts.svh"

module fetch_queue (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  fetch_pkg::fetch_rsp_t  rsp_i,
  input  logic                   flush_i,
  input  logic                   pop0_i,
  input  logic                   pop1_i,
  output logic [`FQ_CNT_W-1:0]   free_parcels_o,
  output fetch_pkg::ir_reg_t     head0_o,
  output fetch_pkg::ir_reg_t     head1_o,
  output logic [1:0]             head_valid_o
);

  localparam int unsigned DEPTH = `FQ_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = `FQ_CNT_W;

  logic [15:0] parcel_q [DEPTH];
  logic [31:0] pc_q     [DEPTH];
  logic        err_q    [DEPTH];

  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [PTR_W-1:0] idx1;
  logic [2:0]       need0, need1, wr_n, pop_n;

  // wrap also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p,
                                               input int unsigned n);
    int unsigned s;
    s = p + n;
    if (s >= DEPTH) begin
      s = s - DEPTH;
    end
    return PTR_W'(s);
  endfunction

  // instruction starting at parcel i, upper half from the next slot
  function automatic fetch_pkg::ir_reg_t make_ir(input logic [PTR_W-1:0] i);
    fetch_pkg::ir_reg_t ir;
    logic [PTR_W-1:0]   j;
    logic               long_w;
    j             = ptr_add(i, 1);
    long_w        = parcel_q[i][1:0] == 2'b11;
    ir.instr      = long_w ? {parcel_q[j], parcel_q[i]} : {16'h0000, parcel_q[i]};
    ir.pc         = pc_q[i];
    ir.is_comp    = !long_w;
    ir.err        = err_q[i] | (long_w & err_q[j]);
    ir.illegal    = 1'b0;
    return ir;
  endfunction

  assign need0 = parcel_q[rd_ptr_q][1:0] == 2'b11 ? 3'd2 : 3'd1;
  assign idx1  = ptr_add(rd_ptr_q, need0);
  assign need1 = parcel_q[idx1][1:0] == 2'b11 ? 3'd2 : 3'd1;

  assign head0_o = make_ir(rd_ptr_q);
  assign head1_o = make_ir(idx1);

  // a head counts only once all its parcels are in
  assign head_valid_o[0] = count_q >= CNT_W'(need0);
  assign head_valid_o[1] = count_q >= CNT_W'(need0 + need1);

  assign wr_n  = rsp_i.valid ? 3'(`FETCH_PARCELS - rsp_i.first) : 3'd0;
  assign pop_n = pop0_i ? (pop1_i ? need0 + need1 : need0) : 3'd0;

  assign free_parcels_o = CNT_W'(DEPTH) - count_q;

  // parcel storage
  always_ff @(posedge clk_i) begin
    if (rsp_i.valid && !flush_i) begin
      for (int k = 0; k < `FETCH_PARCELS; k++) begin
        if (k >= rsp_i.first) begin
          parcel_q[ptr_add(wr_ptr_q, k - rsp_i.first)] <= rsp_i.rdata[16*k +: 16];
          pc_q[ptr_add(wr_ptr_q, k - rsp_i.first)]     <= rsp_i.word_pc + 32'(2 * k);
          err_q[ptr_add(wr_ptr_q, k - rsp_i.first)]    <= rsp_i.err;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      rd_ptr_q <= ptr_add(rd_ptr_q, pop_n);
      wr_ptr_q <= ptr_add(wr_ptr_q, wr_n);
      count_q  <= count_q + CNT_W'(wr_n) - CNT_W'(pop_n);
    end
  end

  // room was checked by the controller before the request went out
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_i.valid && !flush_i |-> CNT_W'(wr_n) <= free_parcels_o);

  a_pop_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop1_i |-> pop0_i);

endmodule

`default_nettype wire

//--- verilog/branch_predict.sv
/*
 * Static branch predictor
 * Predicts JAL, C.J and backward branches taken at the two queue heads,
 * gates the slot valids and merges the execute redirect.
 */

`default_nettype none

module branch_predict (
  input  logic                ex_pc_set_i,
  input  logic [31:0]         ex_pc_target_i,
  input  fetch_pkg::ir_reg_t  head0_i,
  input  fetch_pkg::ir_reg_t  head1_i,
  input  logic [1:0]          head_valid_i,
  input  logic [1:0]          ds_rdy_i,
  output logic                pop0_o,
  output logic                pop1_o,
  output logic [1:0]          valid_o,
  output logic                redirect_o,
  output logic [31:0]         redirect_pc_o
);

  logic        taken0, taken1;
  logic [31:0] target0, target1;
  logic        pred_set;
  logic [31:0] pred_pc;

  function automatic void predict(input fetch_pkg::ir_reg_t ir, output logic taken,
                                  output logic [31:0] target);
    logic [15:0] c;
    logic [31:0] w;
    logic [31:0] imm;
    c     = ir.instr[15:0];
    w     = ir.instr;
    imm   = 32'd0;
    taken = 1'b0;
    if (ir.is_comp) begin
      if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
        // C.J
        imm   = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        taken = 1'b1;
      end else if (c[1:0] == 2'b01 && c[15:14] == 2'b11) begin
        // C.BEQZ, C.BNEZ
        imm   = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
        taken = c[12];
      end
    end else if (w[6:0] == fetch_pkg::OPC_JAL) begin
      imm   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      taken = 1'b1;
    end else if (w[6:0] == fetch_pkg::OPC_BRANCH) begin
      imm   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      taken = w[31];
    end
    // bus error means the bits are garbage
    taken  = taken && !ir.err;
    target = ir.pc + imm;
  endfunction

  always_comb begin
    predict(head0_i, taken0, target0);
    predict(head1_i, taken1, target1);
  end

  // nothing after a taken head0 goes out in the same cycle
  assign valid_o[0] = head_valid_i[0];
  assign valid_o[1] = head_valid_i[1] && !taken0;

  assign pop0_o = valid_o[0] && ds_rdy_i[0];
  assign pop1_o = pop0_o && valid_o[1] && ds_rdy_i[1];

  assign pred_set = (pop0_o && taken0) || (pop1_o && taken1);
  assign pred_pc  = (pop0_o && taken0) ? target0 : target1;

  // execute redirect wins
  assign redirect_o    = ex_pc_set_i || pred_set;
  assign redirect_pc_o = ex_pc_set_i ? ex_pc_target_i : pred_pc;

endmodule

`default_nettype wire

//--- verilog/compressed_decoder.sv
/*
 * Compressed instruction expander
 * Turns C.ADDI, C.LI, C.MV, C.ADD, C.J, C.BEQZ and C.BNEZ into their
 * 32-bit forms. Other RVC encodings pass through flagged illegal.
 */

`default_nettype none

module compressed_decoder (
  input  fetch_pkg::ir_reg_t instr_i,
  output fetch_pkg::ir_reg_t instr_o
);

  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rs1_p;
  logic [11:0] imm6_sx;

  assign c       = instr_i.instr[15:0];
  assign rd      = c[11:7];
  assign rs2     = c[6:2];
  assign rs1_p   = {2'b01, c[9:7]};
  assign imm6_sx = {{6{c[12]}}, c[12], c[6:2]};

  always_comb begin
    instr_o         = instr_i;
    instr_o.illegal = 1'b0;
    if (instr_i.is_comp) begin
      instr_o.illegal = 1'b1;
      unique case (c[1:0])
        2'b01: begin
          unique case (c[15:13])
            3'b000: begin
              // c.addi -> addi rd, rd, imm
              instr_o.instr   = {imm6_sx, rd, 3'b000, rd, fetch_pkg::OPC_OP_IMM};
              instr_o.illegal = 1'b0;
            end
            3'b010: begin
              // c.li -> addi rd, x0, imm
              instr_o.instr   = {imm6_sx, 5'd0, 3'b000, rd, fetch_pkg::OPC_OP_IMM};
              instr_o.illegal = 1'b0;
            end
            3'b101: begin
              // c.j -> jal x0, offset
              instr_o.instr   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                                 c[12], {8{c[12]}}, 5'd0, fetch_pkg::OPC_JAL};
              instr_o.illegal = 1'b0;
            end
            3'b110,
            3'b111: begin
              // c.beqz / c.bnez -> beq / bne rs1', x0, offset
              instr_o.instr   = {c[12], {3{c[12]}}, c[6:5], c[2], 5'd0, rs1_p,
                                 2'b00, c[13], c[11:10], c[4:3], c[12],
                                 fetch_pkg::OPC_BRANCH};
              instr_o.illegal = 1'b0;
            end
            default: ;
          endcase
        end
        2'b10: begin
          // rs2 of zero is c.jr / c.jalr / c.ebreak, not covered
          if (c[15:13] == 3'b100 && rs2 != 5'd0) begin
            if (c[12]) begin
              // c.add -> add rd, rd, rs2
              instr_o.instr = {7'd0, rs2, rd, 3'b000, rd, fetch_pkg::OPC_OP};
            end else begin
              // c.mv -> add rd, x0, rs2
              instr_o.instr = {7'd0, rs2, 5'd0, 3'b000, rd, fetch_pkg::OPC_OP};
            end
            instr_o.illegal = 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/if_stage.sv
/*
 * Instruction fetch stage
 * Fetches 64-bit words, aligns two instructions per cycle, predicts
 * static branches and expands compressed instructions for decode.
 */

`default_nettype none

`include "fetch_consts.svh"

module if_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_i,
  input  logic [31:0]          boot_addr_i,

  // instruction memory port
  output logic                 instr_req_o,
  output logic [31:0]          instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [`FETCH_W-1:0]  instr_rdata_i,
  input  logic                 instr_err_i,

  // toward decode
  input  logic [1:0]           ds_rdy_i,
  output fetch_pkg::ir_reg_t   if_instr0_o,
  output fetch_pkg::ir_reg_t   if_instr1_o,
  output logic [1:0]           if_valid_o,

  // from execute
  input  logic                 ex_pc_set_i,
  input  logic [31:0]          ex_pc_target_i,

  output logic                 if_busy_o
);

  fetch_pkg::fetch_rsp_t   rsp;
  fetch_pkg::ir_reg_t      head0, head1;
  logic [`FQ_CNT_W-1:0]    free_parcels;
  logic [1:0]              head_valid;
  logic                    pop0, pop1;
  logic                    redirect;
  logic [31:0]             redirect_pc;

  fetch_ctrl u_fetch_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .free_parcels_i (free_parcels),
    .redirect_i     (redirect),
    .redirect_pc_i  (redirect_pc),
    .rsp_o          (rsp),
    .busy_o         (if_busy_o)
  );

  // any redirect empties the queue
  fetch_queue u_fetch_queue (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rsp_i          (rsp),
    .flush_i        (redirect),
    .pop0_i         (pop0),
    .pop1_i         (pop1),
    .free_parcels_o (free_parcels),
    .head0_o        (head0),
    .head1_o        (head1),
    .head_valid_o   (head_valid)
  );

  branch_predict u_branch_predict (
    .ex_pc_set_i    (ex_pc_set_i),
    .ex_pc_target_i (ex_pc_target_i),
    .head0_i        (head0),
    .head1_i        (head1),
    .head_valid_i   (head_valid),
    .ds_rdy_i       (ds_rdy_i),
    .pop0_o         (pop0),
    .pop1_o         (pop1),
    .valid_o        (if_valid_o),
    .redirect_o     (redirect),
    .redirect_pc_o  (redirect_pc)
  );

  compressed_decoder cdec0 (
    .instr_i (head0),
    .instr_o (if_instr0_o)
  );

  compressed_decoder cdec1 (
    .instr_i (head1),
    .instr_o (if_instr1_o)
  );

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
/*
 * Testbench clock and reset
 * Free running clock with period 10 and a reset held low for 4 cycles.
 */

`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- test/tb_if_stage.sv
/*
 * Fetch stage testbench
 * Random program in a small memory with random grant and response delays,
 * random back-pressure and redirects. A reference pc model and
 * concurrent assertions check every consumed instruction.
 */

`default_nettype none

module tb_if_stage;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0102;
  localparam int          ERR_WORD  = 20;
  localparam int          N_INSTR   = 600;
  localparam int          MAX_CYC   = 40000;

  logic        clk_i, rst_n_i, req_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o;
  logic [63:0] instr_rdata_i;
  logic [1:0]  ds_rdy_i, if_valid_o;
  logic        ex_pc_set_i, if_busy_o;
  logic [31:0] ex_pc_target_i;
  fetch_pkg::ir_reg_t if_instr0_o, if_instr1_o;

  // 512 bytes of program, addresses wrap
  logic [15:0] mem [256];

  int errors;
  int timeouts;
  int consumed;

  tb_clkgen u_clkgen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  if_stage DUT (
    .clk_i, .rst_n_i, .req_i, .boot_addr_i(BOOT_ADDR),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .instr_err_i, .ds_rdy_i, .if_instr0_o, .if_instr1_o, .if_valid_o,
    .ex_pc_set_i, .ex_pc_target_i, .if_busy_o
  );

  function automatic logic [15:0] parcel_at(input logic [31:0] a);
    return mem[a[8:1]];
  endfunction

  // RVC subset to 32-bit, bit 32 flags an unsupported encoding
  function automatic logic [32:0] expand(input logic [15:0] c);
    logic [20:0] j;
    logic [12:0] b;
    logic [11:0] i6;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    i6 = {{6{c[12]}}, c[12], c[6:2]};
    j  = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    b  = {{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    rd  = c[11:7];
    rs2 = c[6:2];
    if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
      return {1'b0, i6, rd, 3'b000, rd, 7'h13};
    end else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
      return {1'b0, i6, 5'd0, 3'b000, rd, 7'h13};
    end else if (c[1:0] == 2'b01 && c[15:13] == 3'b101) begin
      return {1'b0, j[20], j[10:1], j[11], j[19:12], 5'd0, 7'h6f};
    end else if (c[1:0] == 2'b01 && c[15:14] == 2'b11) begin
      return {1'b0, b[12], b[10:5], 5'd0, 2'b01, c[9:7], 2'b00, c[13], b[4:1], b[11], 7'h63};
    end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0) begin
      return {1'b0, 7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
    end
    return {1'b1, 16'h0000, c};
  endfunction

  function automatic logic err_word(input logic [31:0] a);
    return int'(a[8:3]) == ERR_WORD;
  endfunction

  // expected record for the instruction starting at pc
  function automatic fetch_pkg::ir_reg_t instr_at(input logic [31:0] pc);
    fetch_pkg::ir_reg_t ir;
    logic [15:0] p;
    logic [32:0] x;
    p  = parcel_at(pc);
    ir.pc = pc;
    if (p[1:0] == 2'b11) begin
      ir.instr   = {parcel_at(pc + 32'd2), p};
      ir.is_comp = 1'b0;
      ir.illegal = 1'b0;
      ir.err     = err_word(pc) || err_word(pc + 32'd2);
    end else begin
      x = expand(p);
      ir.instr   = x[31:0];
      ir.is_comp = 1'b1;
      ir.illegal = x[32];
      ir.err     = err_word(pc);
    end
    return ir;
  endfunction

  // jumps always, branches when backward; errored fetches never
  function automatic logic predicts_taken(input fetch_pkg::ir_reg_t ir);
    if (ir.err) begin
      return 1'b0;
    end
    return ir.instr[6:0] == 7'h6f || (ir.instr[6:0] == 7'h63 && ir.instr[31]);
  endfunction

  function automatic logic [31:0] jump_target(input fetch_pkg::ir_reg_t ir);
    logic [31:0] w;
    w = ir.instr;
    if (w[6:0] == 7'h6f) begin
      return ir.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    end
    return ir.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  // reference model state
  logic [31:0] exp_pc;
  logic        halted, stale, waiting, first_req;
  fetch_pkg::ir_reg_t exp0, exp1;
  logic        taken0, taken1, pop0, pop1, redirect_now;

  always_comb begin
    exp0   = instr_at(exp_pc);
    exp1   = instr_at(exp_pc + (exp0.is_comp ? 32'd2 : 32'd4));
    taken0 = predicts_taken(exp0);
    taken1 = predicts_taken(exp1);
    pop0   = if_valid_o[0] && ds_rdy_i[0];
    pop1   = pop0 && if_valid_o[1] && ds_rdy_i[1];
    redirect_now = ex_pc_set_i || (pop0 && taken0) || (pop1 && taken1);
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exp_pc    <= BOOT_ADDR;
      halted    <= 1'b0;
      stale     <= 1'b0;
      waiting   <= 1'b0;
      first_req <= 1'b1;
    end else begin
      if (ex_pc_set_i) begin
        exp_pc <= ex_pc_target_i;
      end else if (pop1) begin
        exp_pc <= taken1 ? jump_target(exp1) : exp1.pc + (exp1.is_comp ? 32'd2 : 32'd4);
      end else if (pop0) begin
        exp_pc <= taken0 ? jump_target(exp0) : exp1.pc;
      end
      consumed <= consumed + int'(pop0) + int'(pop1);
      if (instr_req_o) begin
        first_req <= 1'b0;
      end
      if (instr_req_o && instr_gnt_i) begin
        waiting <= 1'b1;
      end else if (instr_rvalid_i) begin
        waiting <= 1'b0;
      end
      // response of a request overtaken by a redirect is dropped
      if (redirect_now && (instr_req_o || (waiting && !instr_rvalid_i))) begin
        stale <= 1'b1;
      end else if (instr_rvalid_i) begin
        stale <= 1'b0;
      end
      if (redirect_now) begin
        halted <= 1'b0;
      end else if (instr_rvalid_i && instr_err_i && !stale) begin
        halted <= 1'b1;
      end
    end
  end

  a_idle_before_req: assert property (@(posedge clk_i)
    !req_i |-> !instr_req_o && !if_busy_o && if_valid_o == 2'b00)
    else begin
      errors++;
      $display("Fail %0t: activity before req_i", $time);
    end

  a_first_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    first_req && instr_req_o |-> instr_addr_o == {BOOT_ADDR[31:3], 3'b000})
    else begin
      errors++;
      $display("Fail %0t: first address %h", $time, instr_addr_o);
    end

  // busy from request until its response has come back
  a_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    if_busy_o == (instr_req_o || waiting))
    else begin
      errors++;
      $display("Fail %0t: if_busy_o is %b", $time, if_busy_o);
    end

  a_slot0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop0 |-> if_instr0_o == exp0)
    else begin
      errors++;
      $display("Fail %0t: slot 0 got %h expected %h", $time, if_instr0_o, exp0);
    end

  a_slot1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop1 |-> if_instr1_o == exp1)
    else begin
      errors++;
      $display("Fail %0t: slot 1 got %h expected %h", $time, if_instr1_o, exp1);
    end

  a_taken_alone: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop0 && taken0 |-> !pop1)
    else begin
      errors++;
      $display("Fail %0t: slot 1 consumed after taken", $time);
    end

  a_halt_on_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    halted |-> !instr_req_o)
    else begin
      errors++;
      $display("Fail %0t: request after bus error", $time);
    end

  // memory model with random grant and response delays
  int          delay;
  logic [31:0] mem_addr;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      instr_err_i    <= 1'b0;
      instr_rdata_i  <= '0;
      delay          <= -1;
    end else begin
      instr_rvalid_i <= 1'b0;
      instr_gnt_i    <= instr_req_o && !instr_gnt_i && delay < 0 && !instr_rvalid_i &&
                        ($urandom % 3 == 0);
      if (instr_req_o && instr_gnt_i) begin
        mem_addr <= instr_addr_o;
        delay    <= int'($urandom % 4);
      end else if (delay == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_err_i    <= err_word(mem_addr);
        instr_rdata_i  <= {mem[{mem_addr[8:3], 2'd3}], mem[{mem_addr[8:3], 2'd2}],
                           mem[{mem_addr[8:3], 2'd1}], mem[{mem_addr[8:3], 2'd0}]};
        delay          <= -1;
      end else if (delay > 0) begin
        delay <= delay - 1;
      end
    end
  end

  // decode and execute side stimulus
  always @(posedge clk_i) begin
    if (rst_n_i && req_i) begin
      ds_rdy_i       <= 2'($urandom);
      ex_pc_set_i    <= $urandom % 40 == 0;
      ex_pc_target_i <= {23'd0, 8'($urandom), 1'b0};
    end
  end

  task automatic build_program();
    int i;
    logic [31:0] r;
    i = 0;
    while (i < 256) begin
      r = $urandom;
      case ($urandom % 11)
        0: mem[i] = {3'b000, r[10:0], 2'b01};
        1: mem[i] = {3'b010, r[10:0], 2'b01};
        2: mem[i] = {3'b100, r[0], r[5:1], 4'd0, r[6] | 1'b1, 2'b10};
        3: mem[i] = {3'b101, r[10:0], 2'b01};
        4: mem[i] = {2'b11, r[11:0], 2'b01};
        5: mem[i] = {3'b010, r[10:0], 2'b00};
        6: mem[i] = {4'b1000, r[4:0], 5'd0, 2'b10};
        default: mem[i] = 16'h0001;
      endcase
      // wider encodings when both parcels fit
      if ($urandom % 2 == 0 && i < 255) begin
        case ($urandom % 3)
          0: {mem[i + 1], mem[i]} = {r[31:15], 3'b000, r[11:7], 7'h13};
          1: {mem[i + 1], mem[i]} = {r[31:12], r[11:7], 7'h6f};
          default: {mem[i + 1], mem[i]} = {r[31:25], r[24:15], 3'b000, r[11:7], 7'h63};
        endcase
        i = i + 2;
      end else begin
        i = i + 1;
      end
    end
  endtask

  initial begin
    int cyc;
    errors   = 0;
    timeouts = 0;
    consumed = 0;
    void'($urandom(32'h5ebd));
    build_program();
    req_i          = 1'b0;
    ds_rdy_i       = 2'b00;
    ex_pc_set_i    = 1'b0;
    ex_pc_target_i = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_err_i    = 1'b0;
    instr_rdata_i  = '0;
    cyc = 0;
    while (!rst_n_i && cyc < 20) begin
      @(posedge clk_i);
      cyc++;
    end
    if (!rst_n_i) begin
      timeouts++;
      $display("reset never released");
    end
    repeat (3) @(posedge clk_i);
    req_i <= 1'b1;
    cyc = 0;
    while (consumed < N_INSTR && cyc < MAX_CYC) begin
      @(posedge clk_i);
      cyc++;
    end
    if (consumed < N_INSTR) begin
      timeouts++;
      $display("timed out with only %0d instructions consumed", consumed);
    end
    $display("checks failed: %0d, timeouts: %0d, consumed: %0d", errors, timeouts, consumed);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/fetch_queue.sv
verilog/branch_predict.sv
verilog/compressed_decoder.sv
verilog/if_stage.sv
test/tb_clkgen.sv
test/tb_if_stage.sv

//--- Makefile
TOP := tb_if_stage
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
